// File: files.f
rtl/div_pkg.sv
rtl/div_io_if.sv
rtl/long_div.sv
rtl/div_ctrl.sv
rtl/div_wb_regs.sv
rtl/div_top.sv
sim/tb_div_top.sv

// File: rtl/div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// divider sequencer
// one init cycle, DIV_STEPS advance cycles and one correction cycle
module div_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic d_init,
	output logic e_advance,
	output logic e_last,
	output logic busy,
	output logic done
);

	// last count value seen in ADVANCE
	localparam logic [3:0] LAST_STEP = 4'(div_pkg::DIV_STEPS - 1);

	div_pkg::div_state_e state;
	logic [3:0]          step_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= div_pkg::IDLE;
			step_cnt <= 4'd0;
			busy     <= 1'b0;
			done     <= 1'b0;
		end else begin
			case (state)
				div_pkg::IDLE: begin
					// starts outside IDLE are dropped
					if (start) begin
						state <= div_pkg::INIT;
						busy  <= 1'b1;
						done  <= 1'b0;
					end
				end
				div_pkg::INIT: begin
					state    <= div_pkg::ADVANCE;
					step_cnt <= 4'd0;
				end
				div_pkg::ADVANCE: begin
					step_cnt <= step_cnt + 4'd1;
					if (step_cnt == LAST_STEP) begin
						state <= div_pkg::LAST;
					end
				end
				div_pkg::LAST: begin
					// done is sticky until the next accepted start
					state <= div_pkg::IDLE;
					busy  <= 1'b0;
					done  <= 1'b1;
				end
				default: begin
					state <= div_pkg::IDLE;
				end
			endcase
		end
	end

	// strobes decode straight from the state
	assign d_init    = (state == div_pkg::INIT);
	assign e_advance = (state == div_pkg::ADVANCE);
	assign e_last    = (state == div_pkg::LAST);

endmodule

`default_nettype wire

// File: rtl/div_io_if.sv
`timescale 1ns/1ps
`default_nettype none

// operand and result bundle between the bus slave and the divider datapath
interface div_io_if (
	input logic clk
);

	// operands as written by the bus master
	logic [31:0]       dividend;
	logic [31:0]       divisor;
	div_pkg::div_op_e  op;

	// results, valid from the last step onwards
	logic [31:0]       quot;
	logic [31:0]       remd;

	// register block side
	modport regs (
		input  clk,
		output dividend,
		output divisor,
		output op,
		input  quot,
		input  remd
	);

	// datapath side
	modport datapath (
		input  clk,
		input  dividend,
		input  divisor,
		input  op,
		output quot,
		output remd
	);

endinterface

`default_nettype wire

// File: rtl/div_pkg.sv
`default_nettype none

package div_pkg;

	// ####################
	// opcode and sequencer state
	// ####################

	// one bit wide so it lines up with the unsigned bit of the control word
	typedef enum logic {
		DIV_SIGNED   = 1'b0,
		DIV_UNSIGNED = 1'b1
	} div_op_e;

	// init latches operands, advance runs the radix-4 steps
	// last is the ones' to twos' complement correction cycle
	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		INIT    = 2'd1,
		ADVANCE = 2'd2,
		LAST    = 2'd3
	} div_state_e;

	// two quotient bits per step for a 32-bit quotient
	localparam int unsigned DIV_STEPS = 16;

	// ####################
	// register map
	// ####################

	// word offsets taken from byte address bits [4:2]
	localparam logic [2:0] REG_DIVIDEND = 3'd0;
	localparam logic [2:0] REG_DIVISOR  = 3'd1;
	localparam logic [2:0] REG_CTRL     = 3'd2;
	localparam logic [2:0] REG_STATUS   = 3'd3;
	localparam logic [2:0] REG_QUOT     = 3'd4;
	localparam logic [2:0] REG_REMD     = 3'd5;

	// control and status word bit positions
	localparam int unsigned CTRL_START_BIT    = 0;
	localparam int unsigned CTRL_UNSIGNED_BIT = 1;
	localparam int unsigned STATUS_BUSY_BIT   = 0;
	localparam int unsigned STATUS_DONE_BIT   = 1;

endpackage

`default_nettype wire

// File: rtl/div_top.sv
`timescale 1ns/1ps
`default_nettype none

// divide unit on a wishbone classic bus
// bus slave, sequencer and radix-4 datapath
module div_top #(
	parameter int unsigned ADDR_W = 5
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [ADDR_W-1:0] wb_adr,
	input  logic [31:0]       wb_dat_w,
	input  logic              wb_we,
	input  logic [3:0]        wb_sel,
	input  logic              wb_stb,
	input  logic              wb_cyc,
	output logic [31:0]       wb_dat_r,
	output logic              wb_ack
);

	logic start;
	logic d_init;
	logic e_advance;
	logic e_last;
	logic busy;
	logic done;

	// operands and results between slave and datapath
	div_io_if io (
		.clk (clk)
	);

	div_wb_regs #(
		.ADDR_W (ADDR_W)
	) u_regs (
		.clk   (clk),
		.reset (reset),
		.adr   (wb_adr),
		.dat_w (wb_dat_w),
		.we    (wb_we),
		.sel   (wb_sel),
		.stb   (wb_stb),
		.cyc   (wb_cyc),
		.busy  (busy),
		.done  (done),
		.dat_r (wb_dat_r),
		.ack   (wb_ack),
		.start (start),
		.io    (io.regs)
	);

	div_ctrl u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.d_init    (d_init),
		.e_advance (e_advance),
		.e_last    (e_last),
		.busy      (busy),
		.done      (done)
	);

	long_div u_div (
		.clk       (clk),
		.d_init    (d_init),
		.e_advance (e_advance),
		.e_last    (e_last),
		.io        (io.datapath)
	);

endmodule

`default_nettype wire

// File: rtl/div_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic slave for the divider
// every cycle is answered with a single ack one clock after stb and cyc
module div_wb_regs #(
	parameter int unsigned ADDR_W = 5
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [ADDR_W-1:0] adr,
	input  logic [31:0]       dat_w,
	input  logic              we,
	input  logic [3:0]        sel,
	input  logic              stb,
	input  logic              cyc,
	input  logic              busy,
	input  logic              done,
	output logic [31:0]       dat_r,
	output logic              ack,
	output logic              start,
	div_io_if.regs            io
);

	logic [2:0]       offset;
	logic             access;
	logic             wr;
	logic [31:0]      dividend_r;
	logic [31:0]      divisor_r;
	div_pkg::div_op_e op_r;
	logic [31:0]      quot_r;
	logic [31:0]      remd_r;
	logic [31:0]      status;
	logic [31:0]      ctrl;
	logic [31:0]      rd_data;

	// ####################
	// bus decode
	// ####################

	// byte address to word offset, upper bits ignored
	assign offset = adr[4:2];

	// first cycle of stb and cyc, ack goes out on the next edge
	assign access = stb & cyc & ~ack;
	assign wr     = access & we;

	// start lands on the same edge that raises ack
	assign start = wr & (offset == div_pkg::REG_CTRL) & dat_w[div_pkg::CTRL_START_BIT];

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	// ####################
	// operand and control registers
	// ####################

	// sel is not decoded so every write stores the whole word
	always_ff @(posedge clk) begin
		if (wr && offset == div_pkg::REG_DIVIDEND) begin
			dividend_r <= dat_w;
		end
		if (wr && offset == div_pkg::REG_DIVISOR) begin
			divisor_r <= dat_w;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_r <= div_pkg::DIV_SIGNED;
		end else if (wr && offset == div_pkg::REG_CTRL) begin
			op_r <= div_pkg::div_op_e'(dat_w[div_pkg::CTRL_UNSIGNED_BIT]);
		end
	end

	assign io.dividend = dividend_r;
	assign io.divisor  = divisor_r;
	assign io.op       = op_r;

	// ####################
	// results
	// ####################

	// follow the datapath while busy
	// the final load is on the edge that ends the correction cycle
	// which is the same edge where done rises
	always_ff @(posedge clk) begin
		if (reset) begin
			quot_r <= 32'd0;
			remd_r <= 32'd0;
		end else if (busy) begin
			quot_r <= io.quot;
			remd_r <= io.remd;
		end
	end

	// ####################
	// read mux
	// ####################

	always_comb begin
		status = 32'd0;
		status[div_pkg::STATUS_BUSY_BIT] = busy;
		status[div_pkg::STATUS_DONE_BIT] = done;
		// start bit is a strobe and reads back as zero
		ctrl = 32'd0;
		ctrl[div_pkg::CTRL_UNSIGNED_BIT] = op_r;
		case (offset)
			div_pkg::REG_DIVIDEND: rd_data = dividend_r;
			div_pkg::REG_DIVISOR:  rd_data = divisor_r;
			div_pkg::REG_CTRL:     rd_data = ctrl;
			div_pkg::REG_STATUS:   rd_data = status;
			div_pkg::REG_QUOT:     rd_data = quot_r;
			div_pkg::REG_REMD:     rd_data = remd_r;
			default:               rd_data = 32'd0;
		endcase
	end

	// read data is registered with the ack
	always_ff @(posedge clk) begin
		if (access) begin
			dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: rtl/long_div.sv
`timescale 1ns/1ps
`default_nettype none

// radix-4 restoring divider, 16 steps plus one correction cycle
// the quotient builds up in the dividend register two bits per step
module long_div (
	input  logic       clk,
	input  logic       d_init,
	input  logic       e_advance,
	input  logic       e_last,
	div_io_if.datapath io
);

	logic        unsign;
	logic        sign_divisor;
	logic        sign_dividend;
	logic [31:0] dvs;
	logic        sign_dvs;
	logic        sign_dvd;
	logic        sign_quot;
	logic [31:0] dvd;
	logic [34:0] rem;
	logic        step;
	logic        sub;
	logic [34:0] rem_shift;
	logic [34:0] dvs_ivt;
	logic [34:0] rem_sub1;
	logic [34:0] rem_sub2;
	logic [34:0] sub3_ps;
	logic [34:0] sub3_pc;
	logic [34:0] rem_sub3;
	logic        sign_rem1;
	logic        sign_rem2;
	logic        sign_rem3;
	logic        quot_1;
	logic        quot_0;

	// ####################
	// operand latch
	// ####################

	// unsigned division treats both words as positive
	assign unsign        = (io.op == div_pkg::DIV_UNSIGNED);
	assign sign_divisor  = io.divisor[31] & ~unsign;
	assign sign_dividend = io.dividend[31] & ~unsign;

	always_ff @(posedge clk) begin
		if (d_init) begin
			dvs       <= io.divisor;
			sign_dvs  <= sign_divisor;
			sign_dvd  <= sign_dividend;
			sign_quot <= sign_divisor ^ sign_dividend;
		end
	end

	// registers only move on advance
	// the correction cycle holds them so the output adder can settle
	assign step = e_advance & ~e_last;

	// ####################
	// trial subtraction
	// ####################

	// next two dividend bits shifted into the partial remainder
	assign rem_shift = {rem[32:0], dvd[31:30]};

	// subtract when the quotient is positive, add when it is negative
	// so the remainder magnitude always shrinks toward zero
	assign sub     = ~sign_quot;
	assign dvs_ivt = {35{sub}} ^ {{3{sign_dvs}}, dvs};

	// one and two times the divisor
	assign rem_sub1 = rem_shift + dvs_ivt + {34'd0, sub};
	assign rem_sub2 = rem_shift + {dvs_ivt[33:0], sub} + {34'd0, sub};

	// three times the divisor goes through a carry-save row first
	// sum bits and majority carries of remainder, 2x and 1x terms
	assign sub3_ps = rem_shift ^ {dvs_ivt[33:0], sub} ^ dvs_ivt;
	assign sub3_pc = (rem_shift & {dvs_ivt[33:0], sub})
		| (rem_shift & dvs_ivt)
		| ({dvs_ivt[33:0], sub} & dvs_ivt);

	// carry shifts up one place and the second +1 rides in its lsb
	assign rem_sub3 = sub3_ps + {sub3_pc[33:0], sub} + {34'd0, sub};

	// a trial overshoots when its sign differs from the dividend sign
	// an exact zero reads as positive
	// fine for a positive dividend, and an overshoot for the biased negative one
	assign sign_rem1 = rem_sub1[34] ^ sign_dvd;
	assign sign_rem2 = rem_sub2[34] ^ sign_dvd;
	assign sign_rem3 = rem_sub3[34] ^ sign_dvd;

	// quotient digit 0..3 from the trial signs
	// inverted for a negative quotient which gives ones' complement bits
	assign quot_1 = ~sign_rem2 ^ sign_quot;
	assign quot_0 = ((~sign_rem1 & sign_rem2) | ~sign_rem3) ^ sign_quot;

	// ####################
	// state registers
	// ####################

	// a negative dividend is loaded one less
	// so a partial remainder of zero never hides nonzero low bits
	always_ff @(posedge clk) begin
		if (d_init) begin
			dvd <= io.dividend - {31'd0, sign_dividend};
		end else if (step) begin
			dvd <= {dvd[29:0], quot_1, quot_0};
		end
	end

	// remainder preset to the dividend sign
	// keep the largest multiple that did not overshoot
	always_ff @(posedge clk) begin
		if (d_init) begin
			rem <= {35{sign_dividend}};
		end else if (step) begin
			if (sign_rem1) begin
				rem <= rem_shift;
			end else if (sign_rem2) begin
				rem <= rem_sub1;
			end else if (sign_rem3) begin
				rem <= rem_sub2;
			end else begin
				rem <= rem_sub3;
			end
		end
	end

	// ones' to twos' complement fixup for a negative quotient
	assign io.quot = dvd + {31'd0, sign_quot};
	// the one taken off a negative dividend comes back here
	assign io.remd = rem[31:0] + {31'd0, sign_dvd};

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f files.f \
	--top-module tb_div_top \
	-o Vtb_div_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_div_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST FAIL" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "TEST PASS" "$SIM_LOG"; then
	echo "simulation log has no result line"
	exit 1
fi
exit 0

// File: sim/tb_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_top;

	localparam int ADDR_W = 5;
	localparam int N_RANDOM = 200;
	// directed 8, timing 2, isolation 2
	localparam int N_DIVS = 8 + N_RANDOM + 4;
	localparam int TIMEOUT_CYCLES = 64 * N_DIVS + 200;

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic        uns;
		logic [31:0] q;
		logic [31:0] r;
	} div_result_t;

	logic              clk;
	logic              reset;
	logic [ADDR_W-1:0] wb_adr;
	logic [31:0]       wb_dat_w;
	logic              wb_we;
	logic [3:0]        wb_sel;
	logic              wb_stb;
	logic              wb_cyc;
	logic [31:0]       wb_dat_r;
	logic              wb_ack;

	int          edge_cnt = 0;
	int          last_ack_edge = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	logic [31:0] lfsr = 32'h42c22152;
	div_result_t result_q[$];

	div_top #(
		.ADDR_W (ADDR_W)
	) UUT (
		.clk      (clk),
		.reset    (reset),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_we    (wb_we),
		.wb_sel   (wb_sel),
		.wb_stb   (wb_stb),
		.wb_cyc   (wb_cyc),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	always #10 clk = ~clk;

	// edge counter, also the watchdog
	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
		if (edge_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles, %0d errors so far", edge_cnt, n_errors);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ####################
	// reference model
	// ####################

	// quotient truncates toward zero, remainder follows the dividend sign
	function automatic logic [63:0] ref_div(input logic [31:0] a, input logic [31:0] b,
		input logic uns);
		logic [31:0] ma;
		logic [31:0] mb;
		logic [31:0] q;
		logic [31:0] r;
		if (uns) begin
			q = a / b;
			r = a % b;
		end else begin
			ma = a[31] ? -a : a;
			mb = b[31] ? -b : b;
			q = ma / mb;
			r = ma % mb;
			if (a[31] != b[31]) begin
				q = -q;
			end
			if (a[31]) begin
				r = -r;
			end
		end
		return {q, r};
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// zero divisor and signed overflow have no defined result
	function automatic logic is_excluded(input logic [31:0] a, input logic [31:0] b,
		input logic uns);
		return (b == 32'd0) || (!uns && a == 32'h80000000 && b == 32'hffffffff);
	endfunction

	function automatic logic [31:0] ctrl_word(input logic uns);
		logic [31:0] w;
		w = 32'd0;
		w[div_pkg::CTRL_START_BIT] = 1'b1;
		w[div_pkg::CTRL_UNSIGNED_BIT] = uns;
		return w;
	endfunction

	// ####################
	// wishbone master
	// ####################

	task automatic wait_ack();
		@(negedge clk);
		while (!wb_ack) begin
			@(negedge clk);
		end
		last_ack_edge = edge_cnt;
	endtask

	task automatic wb_write(input logic [2:0] off, input logic [31:0] data);
		@(posedge clk);
		wb_adr   <= {off, 2'b00};
		wb_dat_w <= data;
		wb_we    <= 1'b1;
		wb_sel   <= 4'hf;
		wb_stb   <= 1'b1;
		wb_cyc   <= 1'b1;
		wait_ack();
		@(posedge clk);
		wb_stb <= 1'b0;
		wb_cyc <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic [2:0] off, output logic [31:0] data);
		@(posedge clk);
		wb_adr <= {off, 2'b00};
		wb_we  <= 1'b0;
		wb_stb <= 1'b1;
		wb_cyc <= 1'b1;
		wait_ack();
		data = wb_dat_r;
		@(posedge clk);
		wb_stb <= 1'b0;
		wb_cyc <= 1'b0;
	endtask

	task automatic expect_status(input logic [31:0] st, input logic exp_busy,
		input logic exp_done, input string what);
		n_checks++;
		assert (st[div_pkg::STATUS_BUSY_BIT] == exp_busy
			&& st[div_pkg::STATUS_DONE_BIT] == exp_done) else begin
			n_errors++;
			$display("[FAIL] %0t: %s: status %h, expected busy %0d done %0d",
				$time, what, st, exp_busy, exp_done);
		end
	endtask

	task automatic check_status(input logic exp_busy, input logic exp_done, input string what);
		logic [31:0] st;
		wb_read(div_pkg::REG_STATUS, st);
		expect_status(st, exp_busy, exp_done, what);
	endtask

	// status read whose ack lands exactly on edge target
	task automatic read_status_at(input int target, output logic [31:0] st);
		do begin
			@(negedge clk);
		end while (edge_cnt < target - 2);
		wb_read(div_pkg::REG_STATUS, st);
		assert (last_ack_edge == target) else begin
			n_errors++;
			$display("status read was acked on edge %0d instead of edge %0d",
				last_ack_edge, target);
		end
	endtask

	// ####################
	// division sequences
	// ####################

	task automatic post_result(input logic [31:0] a, input logic [31:0] b, input logic uns,
		input logic [31:0] q, input logic [31:0] r);
		div_result_t res;
		res.a = a;
		res.b = b;
		res.uns = uns;
		res.q = q;
		res.r = r;
		result_q.push_back(res);
	endtask

	task automatic start_div(input logic [31:0] a, input logic [31:0] b, input logic uns);
		wb_write(div_pkg::REG_DIVIDEND, a);
		wb_write(div_pkg::REG_DIVISOR, b);
		wb_write(div_pkg::REG_CTRL, ctrl_word(uns));
	endtask

	// poll until done, then fetch and queue the results
	task automatic finish_div(input logic [31:0] a, input logic [31:0] b, input logic uns,
		output logic [31:0] q, output logic [31:0] r);
		logic [31:0] st;
		st = 32'd0;
		while (!st[div_pkg::STATUS_DONE_BIT]) begin
			wb_read(div_pkg::REG_STATUS, st);
		end
		wb_read(div_pkg::REG_QUOT, q);
		wb_read(div_pkg::REG_REMD, r);
		post_result(a, b, uns, q, r);
	endtask

	task automatic run_div(input logic [31:0] a, input logic [31:0] b, input logic uns,
		output logic [31:0] q, output logic [31:0] r);
		start_div(a, b, uns);
		finish_div(a, b, uns, q, r);
	endtask

	// unsigned case that must not match the signed reading of the same words
	task automatic run_unsigned_case(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] q;
		logic [31:0] r;
		run_div(a, b, 1'b1, q, r);
		n_checks++;
		assert ({q, r} != ref_div(a, b, 1'b0)) else begin
			n_errors++;
			$display("[FAIL] %0t: unsigned %h / %h matches the signed result", $time, a, b);
		end
	endtask

	// timed status read at offset edges after the accepting edge
	task automatic run_timed(input int offset, input logic exp_busy, input logic exp_done);
		logic [31:0] st;
		logic [31:0] q;
		logic [31:0] r;
		int          acc_edge;
		start_div(32'hfedcba98, 32'd12345, 1'b0);
		acc_edge = last_ack_edge;
		check_status(1'b1, 1'b0, "busy right after start");
		read_status_at(acc_edge + offset, st);
		expect_status(st, exp_busy, exp_done, "status at fixed edge after start");
		finish_div(32'hfedcba98, 32'd12345, 1'b0, q, r);
	endtask

	// compares every queued result with the reference
	always @(negedge clk) begin : compare_results
		div_result_t res;
		logic [63:0] exp_qr;
		while (result_q.size() != 0) begin
			res = result_q.pop_front();
			exp_qr = ref_div(res.a, res.b, res.uns);
			n_checks++;
			assert (res.q == exp_qr[63:32] && res.r == exp_qr[31:0]) else begin
				n_errors++;
				$display("[FAIL] %0t: %h / %h uns %0d: quot exp %h got %h, remd exp %h got %h",
					$time, res.a, res.b, res.uns, exp_qr[63:32], res.q, exp_qr[31:0], res.r);
			end
		end
	end

	// ####################
	// stimulus
	// ####################

	initial begin : stimulus
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sh;
		logic [31:0] u;
		logic [31:0] q;
		logic [31:0] r;
		logic [31:0] q2;
		logic [31:0] r2;
		clk = 1'b0;
		reset = 1'b1;
		wb_adr = '0;
		wb_dat_w = 32'd0;
		wb_we = 1'b0;
		wb_sel = 4'h0;
		wb_stb = 1'b0;
		wb_cyc = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// everything reads zero out of reset
		check_status(1'b0, 1'b0, "status after reset");
		wb_read(div_pkg::REG_QUOT, q);
		wb_read(div_pkg::REG_REMD, r);
		n_checks++;
		assert (q == 32'd0 && r == 32'd0) else begin
			n_errors++;
			$display("[FAIL] %0t: results after reset quot %h remd %h", $time, q, r);
		end

		// signed directed cases
		run_div(32'd100, -32'sd7, 1'b0, q, r);
		run_div(-32'sd100, 32'd7, 1'b0, q, r);
		run_div(-32'sd100, -32'sd7, 1'b0, q, r);
		run_div(-32'sd56, 32'd7, 1'b0, q, r);
		run_div(-32'sd13, 32'd1000, 1'b0, q, r);

		// unsigned with the top bit set in dividend, divisor, both
		run_unsigned_case(32'h80000005, 32'd7);
		run_unsigned_case(32'h7fffffff, 32'h80000001);
		run_unsigned_case(32'hfffffff0, 32'h80000001);

		for (int n = 0; n < N_RANDOM; n++) begin
			// shorter divisors give wider quotients
			do begin
				rand_bits(32, a);
				rand_bits(32, b);
				rand_bits(5, sh);
				rand_bits(1, u);
				b = b >> sh[4:0];
			end while (is_excluded(a, b, u[0]));
			run_div(a, b, u[0], q, r);
		end

		// done rises on the 18th edge after the accepting edge
		run_timed(18, 1'b1, 1'b0);
		run_timed(19, 1'b0, 1'b1);

		// writes during a running division
		start_div(-32'sd1234567, 32'd891, 1'b0);
		check_status(1'b1, 1'b0, "busy after start");
		wb_write(div_pkg::REG_DIVIDEND, 32'h0badf00d);
		wb_write(div_pkg::REG_DIVISOR, 32'd3);
		wb_write(div_pkg::REG_CTRL, ctrl_word(1'b1));
		check_status(1'b1, 1'b0, "start while busy");
		finish_div(-32'sd1234567, 32'd891, 1'b0, q, r);

		// results and done hold until the next start
		repeat (2) begin
			check_status(1'b0, 1'b1, "done holds");
			wb_read(div_pkg::REG_QUOT, q2);
			wb_read(div_pkg::REG_REMD, r2);
			n_checks++;
			assert (q2 == q && r2 == r) else begin
				n_errors++;
				$display("[FAIL] %0t: held results changed, quot %h to %h, remd %h to %h",
					$time, q, q2, r, r2);
			end
		end
		start_div(32'd999999, 32'd1000, 1'b1);
		check_status(1'b1, 1'b0, "done cleared by start");
		finish_div(32'd999999, 32'd1000, 1'b1, q, r);

		// let the compare process drain the queue
		repeat (2) @(posedge clk);
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
